/* source/dllp_pkg.sv */
`default_nettype none

package dllp_pkg;

	typedef logic [15:0] dllp_word_t;	// one lane word, earlier byte in 7:0

	// dllp content; dllp_type lands in bits 7:0 so word 0 is the low half
	typedef struct packed {
		logic [23:0] body;	// bytes 1..3, byte 1 lowest
		logic [7:0]  dllp_type;	// byte 0
	} dllp_req_t;

	localparam dllp_word_t DLLP_CRC_SEED = 16'hffff;	// crc start value
	localparam dllp_word_t DLLP_CRC_POLY = 16'hd008;	// reflected poly, shift right

	// example type codes, only used as stimulus values
	localparam logic [7:0] DLLP_TYPE_ACK        = 8'h00;
	localparam logic [7:0] DLLP_TYPE_NAK        = 8'h10;
	localparam logic [7:0] DLLP_TYPE_UPDATEFC_P = 8'h40;

	// content word 0: type byte then body byte 1
	function automatic dllp_word_t dllp_word0(input dllp_req_t r);
		dllp_word0 = {r.body[7:0], r.dllp_type};	// byte 1 high, byte 0 low
	endfunction

	// content word 1: body bytes 2 and 3
	function automatic dllp_word_t dllp_word1(input dllp_req_t r);
		dllp_word1 = r.body[23:8];	// byte 2 low, byte 3 high
	endfunction

	// rebuild the content from the two received words
	function automatic dllp_req_t dllp_join(input dllp_word_t w0, input dllp_word_t w1);
		dllp_req_t r;
		r.dllp_type = w0[7:0];	// byte 0
		r.body      = {w1, w0[15:8]};	// bytes 3,2 over byte 1
		dllp_join   = r;
	endfunction

endpackage

`default_nettype wire

/* source/dllp_crc_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dllp_crc_if;
	import dllp_pkg::*;

	logic       first_phase;	// strobe, fold word 0 into the seed
	logic       second_phase;	// strobe, fold word 1 and finish
	dllp_word_t data_first;	// content word 0
	dllp_word_t data_second;	// content word 1
	dllp_word_t crc;	// registered engine result

	// framer or checker side
	modport user (
		output first_phase,
		output second_phase,
		output data_first,
		output data_second,
		input  crc
	);

	// crc engine side
	modport engine (
		input  first_phase,
		input  second_phase,
		input  data_first,
		input  data_second,
		output crc
	);

endinterface

`default_nettype wire

/* source/dllp_crc16.sv */
`timescale 1ns/1ps
`default_nettype none

module dllp_crc16 (
	input logic      clk,
	input logic      rst_n,
	dllp_crc_if.engine crc_bus
);
	import dllp_pkg::*;

	dllp_word_t crc_q;	// held result
	dllp_word_t crc_next;	// folded value for this cycle
	dllp_word_t din;	// word being folded
	logic       armed;	// first phase seen, second not yet

	// fold 16 bits lsb first, byte 0 before byte 1
	always_comb begin
		crc_next = crc_bus.first_phase ? DLLP_CRC_SEED : crc_q;	// phase 1 restarts
		din      = crc_bus.first_phase ? crc_bus.data_first : crc_bus.data_second;
		for (int i = 0; i < 16; i++) begin
			if (crc_next[0] ^ din[i]) begin
				crc_next = (crc_next >> 1) ^ DLLP_CRC_POLY;	// feedback tap
			end else begin
				crc_next = crc_next >> 1;	// plain shift
			end
		end
		if (crc_bus.second_phase) begin
			crc_next = {~crc_next[7:0], ~crc_next[15:8]};	// invert and swap bytes
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crc_q <= '0;
		end else if (crc_bus.first_phase || crc_bus.second_phase) begin
			crc_q <= crc_next;	// update only on a strobe
		end
	end

	assign crc_bus.crc = crc_q;	// valid from the edge after the strobe

	// phase tracking for the ordering check
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			armed <= 1'b0;
		end else if (crc_bus.first_phase) begin
			armed <= 1'b1;	// intermediate held
		end else if (crc_bus.second_phase) begin
			armed <= 1'b0;	// final value out
		end
	end

	// the two strobes come from one user and never overlap
	a_phase_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(crc_bus.first_phase && crc_bus.second_phase)
	) else $error("crc phases high together");

	// second phase needs an intermediate from an earlier first phase
	a_phase_order: assert property (
		@(posedge clk) disable iff (!rst_n)
		crc_bus.second_phase |-> armed
	) else $error("crc second phase without first phase");

endmodule

`default_nettype wire

/* source/dllp_tx_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module dllp_tx_framer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req_valid,
	output logic                 req_ready,
	input  dllp_pkg::dllp_req_t  req,
	output logic                 tx_valid,
	output logic                 tx_start,
	output dllp_pkg::dllp_word_t tx_data,
	dllp_crc_if.user             crc_bus
);
	import dllp_pkg::*;

	logic       rdy_en;	// ready held off for a cycle out of reset
	logic       act_valid;	// active slot is sending
	logic [1:0] word_idx;	// lane word of the active dllp, 0..2
	dllp_req_t  act_req;	// dllp on the lane
	logic       hold_valid;	// holding slot full
	dllp_req_t  hold_req;	// next dllp waiting

	logic accept;	// request handshake this cycle
	logic act_done;	// crc word going out now
	logic act_free;	// active slot can load at this edge
	logic take_hold;	// holding slot moves to active
	logic take_req;	// request goes straight to active
	logic park_req;	// request goes to holding slot

	assign req_ready = rdy_en && !hold_valid;	// back-pressure only when holding is full
	assign accept    = req_valid && req_ready;
	assign act_done  = act_valid && (word_idx == 2'd2);
	assign act_free  = !act_valid || act_done;
	assign take_hold = act_free && hold_valid;
	assign take_req  = act_free && !hold_valid && accept;
	assign park_req  = accept && !take_req;	// busy, so park it

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdy_en     <= 1'b0;
			act_valid  <= 1'b0;
			word_idx   <= 2'd0;
			hold_valid <= 1'b0;
		end else begin
			rdy_en <= 1'b1;
			if (act_free) begin
				act_valid <= take_hold || take_req;	// next dllp follows with no gap
				word_idx  <= 2'd0;
			end else begin
				word_idx <= word_idx + 2'd1;	// word 0 -> 1 -> crc
			end
			if (take_hold) begin
				hold_valid <= 1'b0;	// accept is blocked in this cycle
			end else if (park_req) begin
				hold_valid <= 1'b1;
			end
		end
	end

	// payload slots
	always_ff @(posedge clk) begin
		if (take_hold) begin
			act_req <= hold_req;
		end else if (take_req) begin
			act_req <= req;
		end
		if (park_req) begin
			hold_req <= req;
		end
	end

	// crc strobes run alongside the content words
	assign crc_bus.first_phase  = act_valid && (word_idx == 2'd0);
	assign crc_bus.second_phase = act_valid && (word_idx == 2'd1);
	assign crc_bus.data_first   = dllp_word0(act_req);
	assign crc_bus.data_second  = dllp_word1(act_req);

	assign tx_valid = act_valid;
	assign tx_start = act_valid && (word_idx == 2'd0);	// marks word 0 only

	always_comb begin
		case (word_idx)
			2'd0:    tx_data = dllp_word0(act_req);
			2'd1:    tx_data = dllp_word1(act_req);
			default: tx_data = crc_bus.crc;	// final crc is ready by now
		endcase
	end

	// a start word is followed by exactly two more words, no start among them
	a_tx_frame: assert property (
		@(posedge clk) disable iff (!rst_n)
		tx_start |=> (tx_valid && !tx_start) [*2]
	) else $error("tx start outside word 0");

endmodule

`default_nettype wire

/* source/dllp_rx_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dllp_rx_checker #(
	parameter int ERR_CNT_W = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 rx_valid,
	input  logic                 rx_start,
	input  dllp_pkg::dllp_word_t rx_data,
	output logic                 dllp_valid,
	output logic                 crc_error,
	output dllp_pkg::dllp_req_t  dllp,
	output logic [ERR_CNT_W-1:0] err_count,
	dllp_crc_if.user             crc_bus
);
	import dllp_pkg::*;

	logic [1:0] word_pos;	// 0 wait start, 1 want word 1, 2 want crc
	dllp_word_t w0_q;	// latched content word 0
	dllp_word_t w1_q;	// latched content word 1
	logic       take_w0;	// word 0 on the lane
	logic       take_w1;	// word 1 on the lane
	logic       crc_check;	// crc word on the lane
	logic       crc_match;	// received crc equals recomputed one

	// a start word always restarts, a cut-off dllp is just dropped
	assign take_w0   = rx_valid && rx_start;
	assign take_w1   = rx_valid && !rx_start && (word_pos == 2'd1);
	assign crc_check = rx_valid && !rx_start && (word_pos == 2'd2);
	assign crc_match = (rx_data == crc_bus.crc);

	assign crc_bus.first_phase  = take_w0;
	assign crc_bus.second_phase = take_w1;
	assign crc_bus.data_first   = rx_data;
	assign crc_bus.data_second  = rx_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			word_pos   <= 2'd0;
			dllp_valid <= 1'b0;
			crc_error  <= 1'b0;
			err_count  <= '0;
		end else begin
			if (take_w0) begin
				word_pos <= 2'd1;
			end else if (take_w1) begin
				word_pos <= 2'd2;
			end else if (crc_check) begin
				word_pos <= 2'd0;	// back to waiting for a start
			end
			dllp_valid <= crc_check && crc_match;	// one-cycle pulses
			crc_error  <= crc_check && !crc_match;
			if (crc_check && !crc_match && (err_count != '1)) begin
				err_count <= err_count + 1'b1;	// saturates at all ones
			end
		end
	end

	// content words, held until the next dllp overwrites them
	always_ff @(posedge clk) begin
		if (take_w0) begin
			w0_q <= rx_data;
		end
		if (take_w1) begin
			w1_q <= rx_data;
		end
	end

	assign dllp = dllp_join(w0_q, w1_q);	// stable during the dllp_valid cycle

	// a result is either a delivery or an error
	a_result_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(dllp_valid && crc_error)
	) else $error("dllp_valid and crc_error together");

endmodule

`default_nettype wire

/* source/dllp_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dllp_link_top #(
	parameter int ERR_CNT_W = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,

	// request side
	input  logic                 req_valid,
	output logic                 req_ready,
	input  logic [7:0]           req_type,
	input  logic [23:0]          req_body,

	// outgoing lane
	output logic                 tx_valid,
	output logic                 tx_start,
	output dllp_pkg::dllp_word_t tx_data,

	// incoming lane
	input  logic                 rx_valid,
	input  logic                 rx_start,
	input  dllp_pkg::dllp_word_t rx_data,

	// delivery
	output logic                 dllp_valid,
	output logic [7:0]           dllp_type,
	output logic [23:0]          dllp_body,
	output logic                 crc_error,
	output logic [ERR_CNT_W-1:0] err_count
);
	import dllp_pkg::*;

	dllp_req_t req_s;	// packed request
	dllp_req_t dllp_s;	// packed delivery

	assign req_s.dllp_type = req_type;
	assign req_s.body      = req_body;
	assign dllp_type       = dllp_s.dllp_type;
	assign dllp_body       = dllp_s.body;

	dllp_crc_if tx_crc_bus ();	// framer to its engine
	dllp_crc_if rx_crc_bus ();	// checker to its engine

	dllp_crc16 i_tx_crc (
		.clk     (clk),
		.rst_n   (rst_n),
		.crc_bus (tx_crc_bus)
	);

	dllp_crc16 i_rx_crc (
		.clk     (clk),
		.rst_n   (rst_n),
		.crc_bus (rx_crc_bus)
	);

	dllp_tx_framer i_tx (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req_s),
		.tx_valid  (tx_valid),
		.tx_start  (tx_start),
		.tx_data   (tx_data),
		.crc_bus   (tx_crc_bus)
	);

	dllp_rx_checker #(
		.ERR_CNT_W (ERR_CNT_W)
	) i_rx (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_valid   (rx_valid),
		.rx_start   (rx_start),
		.rx_data    (rx_data),
		.dllp_valid (dllp_valid),
		.crc_error  (crc_error),
		.dllp       (dllp_s),
		.err_count  (err_count),
		.crc_bus    (rx_crc_bus)
	);

endmodule

`default_nettype wire

/* bench/dllp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dllp_tb;
	import dllp_pkg::*;

	localparam int ERR_CNT_W = 8;
	localparam int N_RAND    = 200;	// random clean requests
	localparam int N_BURST   = 20;	// offered every cycle
	localparam int N_FLIP    = 30;	// one flipped bit each
	localparam int N_GAP     = 30;	// rx gaps, some truncated
	localparam int N_TOTAL   = N_RAND + N_BURST + N_FLIP + N_GAP;
	localparam int WATCHDOG_CYCLES = N_TOTAL * 6 + 200;

	localparam int MODE_CLEAN = 0;
	localparam int MODE_FLIP  = 1;	// flip one bit of one word
	localparam int MODE_CUT   = 2;	// drop the crc word

	logic                 clk;
	logic                 rst_n;
	logic                 req_valid;
	logic                 req_ready;
	logic [7:0]           req_type;
	logic [23:0]          req_body;
	logic                 tx_valid;
	logic                 tx_start;
	dllp_word_t           tx_data;
	logic                 rx_valid;
	logic                 rx_start;
	dllp_word_t           rx_data;
	logic                 dllp_valid;
	logic [7:0]           dllp_type;
	logic [23:0]          dllp_body;
	logic                 crc_error;
	logic [ERR_CNT_W-1:0] err_count;

	logic [31:0] lfsr = 32'h8511d90a;	// stimulus lfsr state
	logic [16:0] tx_exp[$];	// {start, word} in lane order
	logic [32:0] sb[$];	// {crc error expected, type, body}
	int          mode_arr[0:N_TOTAL-1];
	int          inj_word_arr[0:N_TOTAL-1];
	int          inj_bit_arr[0:N_TOTAL-1];
	int          n_issued = 0;
	int          n_flip = 0;
	int          n_cut = 0;
	int          n_err = 0;
	int          n_checks = 0;
	logic        gap_mode = 1'b0;	// loopback holds words back
	logic        burst_on = 1'b0;
	int          burst_words = 0;
	int          burst_first = -1;
	int          burst_last = -1;

	dllp_link_top #(
		.ERR_CNT_W (ERR_CNT_W)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_type   (req_type),
		.req_body   (req_body),
		.tx_valid   (tx_valid),
		.tx_start   (tx_start),
		.tx_data    (tx_data),
		.rx_valid   (rx_valid),
		.rx_start   (rx_start),
		.rx_data    (rx_data),
		.dllp_valid (dllp_valid),
		.dllp_type  (dllp_type),
		.dllp_body  (dllp_body),
		.crc_error  (crc_error),
		.err_count  (err_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v    = {v[30:0], lfsr[0]};
		end
		take_bits = v;
	endfunction

	// link crc over bytes 0..3, lsb first, then invert and swap
	function automatic logic [15:0] crc_ref(input logic [7:0] t, input logic [23:0] b);
		logic [31:0] stream;
		logic [15:0] c;
		stream = {b, t};	// byte 0 in the low bits
		c      = DLLP_CRC_SEED;
		for (int i = 0; i < 32; i++) begin
			if (c[0] ^ stream[i]) begin
				c = (c >> 1) ^ DLLP_CRC_POLY;
			end else begin
				c = c >> 1;
			end
		end
		c       = ~c;
		crc_ref = {c[7:0], c[15:8]};
	endfunction

	task automatic report_mismatch(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		n_err++;
	endtask

	task automatic report_fault(input string msg);
		$display("%s (at %0t)", msg, $time);
		n_err++;
	endtask

	// queue the expectations, then hold the request until it is taken
	task automatic issue(input logic [7:0] t, input logic [23:0] b, input int mode);
		logic [31:0] r;
		mode_arr[n_issued] = mode;
		if (mode == MODE_FLIP) begin
			r = take_bits(2);
			inj_word_arr[n_issued] = int'(r % 3);	// word 0, 1 or crc
			r = take_bits(4);
			inj_bit_arr[n_issued] = int'(r[3:0]);
			n_flip++;
		end
		if (mode == MODE_CUT) begin
			n_cut++;	// never reaches the scoreboard
		end else begin
			sb.push_back({mode == MODE_FLIP, t, b});
		end
		tx_exp.push_back({1'b1, b[7:0], t});
		tx_exp.push_back({1'b0, b[23:8]});
		tx_exp.push_back({1'b0, crc_ref(t, b)});
		n_issued++;
		req_valid = 1'b1;
		req_type  = t;
		req_body  = b;
		while (!req_ready) @(negedge clk);	// back-pressure
		@(negedge clk);	// taken at the edge in between
	endtask

	task automatic send_random(input int mode, input logic idle_ok);
		logic [31:0] r;
		logic [7:0]  t;
		logic [23:0] b;
		r = take_bits(2);
		case (r[1:0])
			2'd0:    t = DLLP_TYPE_ACK;
			2'd1:    t = DLLP_TYPE_NAK;
			2'd2:    t = DLLP_TYPE_UPDATEFC_P;
			default: begin
				r = take_bits(8);
				t = r[7:0];
			end
		endcase
		r = take_bits(24);
		b = r[23:0];
		issue(t, b, mode);
		r = take_bits(2);
		if (idle_ok && r[1:0] != 2'd0) begin
			req_valid = 1'b0;	// idle 1..3 cycles
			repeat (int'(r[1:0])) @(negedge clk);
		end
	endtask

	task automatic wait_drain;
		req_valid = 1'b0;
		while (sb.size() != 0 || tx_exp.size() != 0) @(negedge clk);
		repeat (4) @(negedge clk);
	endtask

	// tx to rx with bit flips, dropped crc words and rx gaps
	initial begin : loopback
		logic [16:0] fifo[$];
		logic [16:0] e;
		dllp_word_t  w;
		int          idx;
		int          word_no;
		int          cnt;
		int          lb_cyc;
		logic        gap;
		rx_valid = 1'b0;
		rx_start = 1'b0;
		rx_data  = '0;
		idx      = 0;
		word_no  = 0;
		cnt      = 0;
		lb_cyc   = 0;
		forever begin
			@(negedge clk);
			if (rst_n && tx_valid) begin
				if (tx_start) begin
					idx     = cnt;	// dllp number in issue order
					cnt     = cnt + 1;
					word_no = 0;
				end else begin
					word_no = word_no + 1;
				end
				w = tx_data;
				if (mode_arr[idx] == MODE_FLIP && inj_word_arr[idx] == word_no) begin
					w[inj_bit_arr[idx]] = ~w[inj_bit_arr[idx]];
				end
				if (!(mode_arr[idx] == MODE_CUT && word_no == 2)) begin
					fifo.push_back({tx_start, w});
				end
			end
			gap    = gap_mode && (lb_cyc % 3 == 1);
			lb_cyc = lb_cyc + 1;
			if (fifo.size() != 0 && !gap) begin
				e        = fifo.pop_front();
				rx_valid = 1'b1;
				rx_start = e[16];
				rx_data  = e[15:0];
			end else begin
				rx_valid = 1'b0;
				rx_start = 1'b0;
			end
		end
	end

	// checks tx words and deliveries where the outputs are settled
	initial begin : compare
		logic [16:0] te;
		logic [32:0] se;
		int          cyc;
		cyc = 0;
		forever begin
			@(negedge clk);
			cyc++;
			if (rst_n && tx_valid) begin
				if (burst_on) begin
					burst_words++;
					if (burst_first < 0) begin
						burst_first = cyc;
					end
					burst_last = cyc;
				end
				if (tx_exp.size() == 0) begin
					report_fault("tx word sent with no request behind it");
				end else begin
					te = tx_exp.pop_front();
					n_checks++;
					if (tx_data != te[15:0] || tx_start != te[16]) begin
						report_mismatch($sformatf("tx word %h start %b, expected %h start %b",
							tx_data, tx_start, te[15:0], te[16]));
					end
				end
			end
			if (rst_n && (dllp_valid || crc_error)) begin
				n_checks++;
				if (dllp_valid && crc_error) begin
					report_fault("dllp_valid and crc_error pulsed together");
				end else if (sb.size() == 0) begin
					report_fault("result pulse with no dllp expected");
				end else begin
					se = sb.pop_front();
					if (crc_error && !se[32]) begin
						report_mismatch($sformatf("crc_error on clean dllp type %h body %h",
							se[31:24], se[23:0]));
					end else if (dllp_valid && se[32]) begin
						report_mismatch("dllp_valid where a crc error was injected");
					end else if (dllp_valid && {dllp_type, dllp_body} != se[31:0]) begin
						report_mismatch($sformatf("dllp type %h body %h, expected %h %h",
							dllp_type, dllp_body, se[31:24], se[23:0]));
					end
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog ran out after %0d cycles, the dut stopped delivering",
			WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

	initial begin : main
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req_type  = '0;
		req_body  = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		n_checks++;
		if (tx_valid || tx_start || dllp_valid || crc_error || req_ready || err_count != '0) begin
			report_mismatch("outputs not idle after reset");
		end
		@(negedge clk);

		for (int k = 0; k < N_RAND; k++) begin
			send_random(MODE_CLEAN, 1'b1);
		end
		wait_drain();

		burst_on = 1'b1;	// tx idle here
		for (int k = 0; k < N_BURST; k++) begin
			send_random(MODE_CLEAN, 1'b0);	// valid stays high
		end
		wait_drain();
		burst_on = 1'b0;
		n_checks++;
		if (burst_words != 3 * N_BURST || burst_last - burst_first + 1 != 3 * N_BURST) begin
			report_mismatch($sformatf("burst took %0d words over %0d cycles, expected %0d",
				burst_words, burst_last - burst_first + 1, 3 * N_BURST));
		end

		for (int k = 0; k < N_FLIP; k++) begin
			send_random(MODE_FLIP, 1'b1);
		end
		wait_drain();
		n_checks++;
		if (err_count != ERR_CNT_W'(n_flip)) begin
			report_mismatch($sformatf("err_count %0d, expected %0d", err_count, n_flip));
		end

		gap_mode = 1'b1;
		for (int k = 0; k < N_GAP; k++) begin
			send_random((k % 6 == 3) ? MODE_CUT : MODE_CLEAN, 1'b1);
		end
		wait_drain();
		n_checks++;
		if (err_count != ERR_CNT_W'(n_flip)) begin
			report_mismatch($sformatf("err_count %0d after gaps, expected %0d", err_count, n_flip));
		end

		$display("checks %0d, errors %0d, flipped %0d, truncated %0d",
			n_checks, n_err, n_flip, n_cut);
		if (n_err == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
source/dllp_pkg.sv
source/dllp_crc_if.sv
source/dllp_crc16.sv
source/dllp_tx_framer.sv
source/dllp_rx_checker.sv
source/dllp_link_top.sv
bench/dllp_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dllp_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
